// File: verilog/conPkg.sv
// Field widths follow the microword bit numbering, so bit 0 is the most significant bit
`default_nettype none

package conPkg;

  // Microword condition field, group in bits 0 to 2 and member in bits 3 to 5
  typedef logic [0:5] condField;

  // Microword magic number field
  typedef logic [0:8] magicField;

  // Diagnostic function sub-select from bus bits 4 to 6
  typedef logic [0:2] diagSel;

  // Next-instruction dispatch code
  typedef logic [0:2] nicondCode;

  // Status bits for bus bits 18 to 24, also the CONO data bits
  typedef logic [0:6] diagByte;

  // Cache look, cache load, paging enable, trap enable
  typedef logic [0:3] pagFlags;

  // Microcode state flags 0 to 3
  typedef logic [0:3] ucodeFlags;

  // Condition field group codes
  localparam logic [0:2] COND_GROUP_SPEC = 3'd1;
  localparam logic [0:2] COND_GROUP_CTL = 3'd2;
  localparam logic [0:2] COND_GROUP_SKIP60 = 3'd6;
  localparam logic [0:2] COND_GROUP_SKIP70 = 3'd7;

  // Bit positions inside the paging latch
  localparam int PAG_EN = 2;
  localparam int PAG_TRAP = 3;

endpackage

`default_nettype wire

// File: verilog/condDecoder.sv
// Every strobe and field is registered once, so all outputs trail their microword by one cycle
`timescale 1ns/1ps
`default_nettype none

module condDecoder (
  input  wire                  clk,
  input  wire                  rst,
  input  conPkg::condField     cond,
  input  conPkg::magicField    magic,
  input  wire                  diagCtlFunc,
  input  conPkg::diagSel       diagDs,
  output logic [0:2]           condSelQ,
  output conPkg::magicField    magicQ,
  output logic                 condSkip60,
  output logic                 condSkip70,
  output logic                 condEboxState,
  output logic                 condSrMagic,
  output logic                 conoPag,
  output logic                 diagSetRun,
  output logic                 diagClrRun,
  output logic                 diagContinue
);

  logic [0:2] condGroup;
  logic [0:2] condMember;
  logic       ctlEn;
  logic       diagFunc;
  logic       magicFunc01x;
  logic       conoPagD;

  assign condGroup = cond[0:2];
  assign condMember = cond[3:5];
  assign ctlEn = (condGroup == conPkg::COND_GROUP_CTL);

  // Magic function 01x is only valid under the diagnostic function member
  assign diagFunc = ctlEn && (condMember == 3'd0);
  assign magicFunc01x = diagFunc && (magic[3:5] == 3'd1);
  assign conoPagD = magicFunc01x && (magic[6:8] == 3'd6);

  always_ff @(posedge clk) begin
    if (rst) begin
      condSelQ <= '0;
      magicQ <= '0;
      condSkip60 <= 1'b0;
      condSkip70 <= 1'b0;
      condEboxState <= 1'b0;
      condSrMagic <= 1'b0;
      conoPag <= 1'b0;
      diagSetRun <= 1'b0;
      diagClrRun <= 1'b0;
      diagContinue <= 1'b0;
    end else begin
      condSelQ <= condMember;
      magicQ <= magic;
      condSkip60 <= (condGroup == conPkg::COND_GROUP_SKIP60);
      condSkip70 <= (condGroup == conPkg::COND_GROUP_SKIP70);
      condEboxState <= ctlEn && (condMember == 3'd1);
      condSrMagic <= ctlEn && (condMember == 3'd6);
      conoPag <= conoPagD;
      // Console run control functions
      diagClrRun <= diagCtlFunc && (diagDs == 3'd0);
      diagSetRun <= diagCtlFunc && (diagDs == 3'd1);
      diagContinue <= diagCtlFunc && (diagDs == 3'd2);
    end
  end

endmodule

`default_nettype wire

// File: verilog/runControl.sv
// Run and start lag their diagnostic strobes by RUN_SYNC_STAGES cycles, which must be 1 or more
`timescale 1ns/1ps
`default_nettype none

module runControl #(
  parameter int RUN_SYNC_STAGES = 3
) (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  diagSetRun,
  input  wire                  diagClrRun,
  input  wire                  diagContinue,
  input  wire                  conoPag,
  input  wire                  condEboxState,
  input  wire                  condSrMagic,
  input  conPkg::magicField    magicQ,
  input  conPkg::diagByte      conoData,
  input  wire                  mtrIntReq,
  input  wire                  piReady,
  input  wire                  intDisable,
  output logic                 run,
  output logic                 start,
  output conPkg::pagFlags      pag,
  output conPkg::ucodeFlags    ucodeState,
  output logic [0:3]           sr,
  output logic                 intReq
);

  // Stage 0 holds the requested state, later stages only delay it
  logic [0:RUN_SYNC_STAGES-1] runSync;
  logic [0:RUN_SYNC_STAGES-1] startSync;

  always_ff @(posedge clk) begin
    if (rst) begin
      runSync <= '0;
      startSync <= '0;
    end else begin
      if (diagSetRun) begin
        runSync[0] <= 1'b1;
      end else if (diagClrRun) begin
        runSync[0] <= 1'b0;
      end
      // Start stays set until the console clears run
      if (diagContinue) begin
        startSync[0] <= 1'b1;
      end else if (diagClrRun) begin
        startSync[0] <= 1'b0;
      end
      for (int k = 1; k < RUN_SYNC_STAGES; k++) begin
        runSync[k] <= runSync[k-1];
        startSync[k] <= startSync[k-1];
      end
    end
  end

  assign run = runSync[RUN_SYNC_STAGES-1];
  assign start = startSync[RUN_SYNC_STAGES-1];

  // CONO PAG latch
  always_ff @(posedge clk) begin
    if (rst) begin
      pag <= '0;
    end else if (conoPag) begin
      pag <= conoData[0:3];
    end
  end

  // Set bit wins, hold bit keeps the flag, otherwise it clears
  always_ff @(posedge clk) begin
    if (rst) begin
      ucodeState <= '0;
    end else if (condEboxState) begin
      for (int i = 0; i < 4; i++) begin
        ucodeState[i] <= magicQ[2*i+1] | (magicQ[2*i+2] & ucodeState[i]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sr <= '0;
    end else if (condSrMagic) begin
      sr <= magicQ[5:8];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      intReq <= 1'b0;
    end else begin
      intReq <= (mtrIntReq | piReady) & ~intDisable;
    end
  end

endmodule

`default_nettype wire

// File: verilog/skipNicond.sv
// Skip, NICOND and diagnostic read data are all registered and use the levels of the current cycle
`timescale 1ns/1ps
`default_nettype none

module skipNicond (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  condSkip60,
  input  wire                  condSkip70,
  input  wire [0:2]            condSelQ,
  input  wire                  run,
  input  wire                  start,
  input  wire                  intReq,
  input  wire                  mtrIntReq,
  input  wire                  piCycle,
  input  wire                  userMode,
  input  wire                  publicMode,
  input  wire                  acRef,
  input  conPkg::pagFlags      pag,
  input  conPkg::ucodeFlags    ucodeState,
  input  wire [0:3]            sr,
  input  wire                  diagReadFunc,
  input  conPkg::diagSel       diagDs,
  output logic                 skip,
  output conPkg::nicondCode    nicond,
  output logic                 nicondTrapEn,
  output conPkg::diagByte      ebusOut,
  output logic                 ebusDrive
);

  logic              kernelMode;
  logic [0:7]        skip60Src;
  logic [0:7]        skip70Src;
  logic              skipD;
  conPkg::nicondCode nicondD;
  conPkg::diagByte   readD;

  assign kernelMode = ~userMode & ~publicMode;

  // Member 0 is the leftmost source
  assign skip60Src = {kernelMode, userMode, publicMode, acRef,
                      piCycle, pag[conPkg::PAG_EN], ~start, pag[conPkg::PAG_TRAP]};
  assign skip70Src = {intReq, ~start, run, kernelMode,
                      acRef, mtrIntReq, ucodeState[0], ~mtrIntReq};

  assign skipD = (condSkip60 & skip60Src[condSelQ]) |
                 (condSkip70 & skip70Src[condSelQ]);

  always_comb begin
    if (piCycle) begin
      nicondD = 3'd0;
    end else if (!run) begin
      nicondD = 3'd1;
    end else if (mtrIntReq) begin
      nicondD = 3'd2;
    end else if (intReq) begin
      nicondD = 3'd3;
    end else if (ucodeState[2]) begin
      nicondD = 3'd4;
    end else if (!acRef) begin
      nicondD = 3'd5;
    end else begin
      nicondD = 3'd7;
    end
  end

  always_comb begin
    case (diagDs)
      3'd0: readD = {run, start, intReq, pag};
      3'd1: readD = {ucodeState, sr[0:2]};
      3'd2: readD = {nicond, nicondTrapEn, skip, 2'b00};
      default: readD = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      skip <= 1'b0;
      // Code 7 means no condition, so trap enable stays consistent with it
      nicond <= 3'd7;
      nicondTrapEn <= 1'b0;
      ebusOut <= '0;
      ebusDrive <= 1'b0;
    end else begin
      skip <= skipD;
      nicond <= nicondD;
      nicondTrapEn <= (nicondD < 3'd4);
      ebusOut <= diagReadFunc ? readD : '0;
      ebusDrive <= diagReadFunc;
    end
  end

endmodule

`default_nettype wire

// File: verilog/conBoard.sv
// CONO data and level inputs are sampled directly, so they must be held through the decode cycle
`timescale 1ns/1ps
`default_nettype none

module conBoard #(
  parameter int RUN_SYNC_STAGES = 3
) (
  input  wire                  clk,
  input  wire                  rst,
  input  conPkg::condField     cond,
  input  conPkg::magicField    magic,
  input  wire                  diagCtlFunc,
  input  wire                  diagReadFunc,
  input  conPkg::diagSel       diagDs,
  input  conPkg::diagByte      conoData,
  input  wire                  mtrIntReq,
  input  wire                  piReady,
  input  wire                  intDisable,
  input  wire                  userMode,
  input  wire                  publicMode,
  input  wire                  acRef,
  input  wire                  piCycle,
  output logic                 run,
  output logic                 start,
  output conPkg::pagFlags      pag,
  output conPkg::ucodeFlags    ucodeState,
  output logic [0:3]           sr,
  output logic                 skip,
  output conPkg::nicondCode    nicond,
  output logic                 nicondTrapEn,
  output conPkg::diagByte      ebusOut,
  output logic                 ebusDrive
);

  logic [0:2]        condSelQ;
  conPkg::magicField magicQ;
  logic              condSkip60;
  logic              condSkip70;
  logic              condEboxState;
  logic              condSrMagic;
  logic              conoPag;
  logic              diagSetRun;
  logic              diagClrRun;
  logic              diagContinue;
  logic              intReq;

  condDecoder i_condDecoder (
    .clk           (clk),
    .rst           (rst),
    .cond          (cond),
    .magic         (magic),
    .diagCtlFunc   (diagCtlFunc),
    .diagDs        (diagDs),
    .condSelQ      (condSelQ),
    .magicQ        (magicQ),
    .condSkip60    (condSkip60),
    .condSkip70    (condSkip70),
    .condEboxState (condEboxState),
    .condSrMagic   (condSrMagic),
    .conoPag       (conoPag),
    .diagSetRun    (diagSetRun),
    .diagClrRun    (diagClrRun),
    .diagContinue  (diagContinue)
  );

  runControl #(
    .RUN_SYNC_STAGES (RUN_SYNC_STAGES)
  ) i_runControl (
    .clk           (clk),
    .rst           (rst),
    .diagSetRun    (diagSetRun),
    .diagClrRun    (diagClrRun),
    .diagContinue  (diagContinue),
    .conoPag       (conoPag),
    .condEboxState (condEboxState),
    .condSrMagic   (condSrMagic),
    .magicQ        (magicQ),
    .conoData      (conoData),
    .mtrIntReq     (mtrIntReq),
    .piReady       (piReady),
    .intDisable    (intDisable),
    .run           (run),
    .start         (start),
    .pag           (pag),
    .ucodeState    (ucodeState),
    .sr            (sr),
    .intReq        (intReq)
  );

  skipNicond i_skipNicond (
    .clk          (clk),
    .rst          (rst),
    .condSkip60   (condSkip60),
    .condSkip70   (condSkip70),
    .condSelQ     (condSelQ),
    .run          (run),
    .start        (start),
    .intReq       (intReq),
    .mtrIntReq    (mtrIntReq),
    .piCycle      (piCycle),
    .userMode     (userMode),
    .publicMode   (publicMode),
    .acRef        (acRef),
    .pag          (pag),
    .ucodeState   (ucodeState),
    .sr           (sr),
    .diagReadFunc (diagReadFunc),
    .diagDs       (diagDs),
    .skip         (skip),
    .nicond       (nicond),
    .nicondTrapEn (nicondTrapEn),
    .ebusOut      (ebusOut),
    .ebusDrive    (ebusDrive)
  );

endmodule

`default_nettype wire

// File: dv/conBoard_asserts.sv
// Bound into every conBoard instance and sees only its top-level outputs, checks are off during reset
`timescale 1ns/1ps
`default_nettype none

module conBoardAsserts #(
  parameter int RUN_SYNC_STAGES = 3
) (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  run,
  input  wire                  start,
  input  conPkg::nicondCode    nicond,
  input  wire                  nicondTrapEn,
  input  conPkg::diagByte      ebusOut,
  input  wire                  ebusDrive
);

  // Consecutive cycles with run low, saturating at the synchronizer depth
  int runLowCycles;

  // Number of assertion failures so far
  int failCount = 0;

  always_ff @(posedge clk) begin
    if (rst || run) begin
      runLowCycles <= 0;
    end else if (runLowCycles < RUN_SYNC_STAGES) begin
      runLowCycles <= runLowCycles + 1;
    end
  end

  ebusQuiet: assert property (@(posedge clk) disable iff (rst) !ebusDrive |-> ebusOut == '0)
    else begin
      $error("ebusOut is nonzero while ebusDrive is low");
      failCount++;
    end

  trapMatch: assert property (@(posedge clk) disable iff (rst) nicondTrapEn == (nicond < 3'd4))
    else begin
      $error("nicondTrapEn does not match nicond %0d", nicond);
      failCount++;
    end

  startWithRun: assert property (@(posedge clk) disable iff (rst)
      $rose(start) |-> runLowCycles < RUN_SYNC_STAGES)
    else begin
      $error("start rose after run had been low for the full synchronizer depth");
      failCount++;
    end

endmodule

bind conBoard conBoardAsserts #(.RUN_SYNC_STAGES(RUN_SYNC_STAGES)) i_conBoardAsserts (
  .clk          (clk),
  .rst          (rst),
  .run          (run),
  .start        (start),
  .nicond       (nicond),
  .nicondTrapEn (nicondTrapEn),
  .ebusOut      (ebusOut),
  .ebusDrive    (ebusDrive)
);

`default_nettype wire

// File: dv/conBoardTb.sv
// Table rows run back to back and share DUT state, so each row's expected value assumes the rows before it
`timescale 1ns/1ps
`default_nettype none

module conBoardTb;

  localparam int SYNC = 3;
  localparam int WAIT_LIMIT = 64;

  // Output selectors for the check of each row
  localparam int SEL_RUN = 0;
  localparam int SEL_START = 1;
  localparam int SEL_RUNSTART = 2;
  localparam int SEL_PAG = 3;
  localparam int SEL_UCODE = 4;
  localparam int SEL_SR = 5;
  localparam int SEL_SKIP = 6;
  localparam int SEL_NICOND = 7;
  localparam int SEL_EBUS = 8;
  localparam int SEL_DRIVE = 9;

  logic clk = 1'b0;
  logic rst;
  conPkg::condField cond;
  conPkg::magicField magic;
  logic diagCtlFunc;
  logic diagReadFunc;
  conPkg::diagSel diagDs;
  conPkg::diagByte conoData;
  logic mtrIntReq;
  logic piReady;
  logic intDisable;
  logic userMode;
  logic publicMode;
  logic acRef;
  logic piCycle;
  logic run;
  logic start;
  conPkg::pagFlags pag;
  conPkg::ucodeFlags ucodeState;
  logic [0:3] sr;
  logic skip;
  conPkg::nicondCode nicond;
  logic nicondTrapEn;
  conPkg::diagByte ebusOut;
  logic ebusDrive;

  string rowName[$];
  logic [0:5] rowCond[$];
  logic [0:8] rowMagic[$];
  bit rowCtl[$];
  bit rowRead[$];
  logic [0:2] rowDs[$];
  logic [0:6] rowCono[$];
  logic [6:0] rowLevels[$];
  int rowLat[$];
  int rowSel[$];
  logic [6:0] rowExp[$];

  always #5 clk = ~clk;

  conBoard #(.RUN_SYNC_STAGES(SYNC)) i_conBoard (.*);

  // A failed bound assertion ends the run at once
  always @(i_conBoard.i_conBoardAsserts.failCount) begin
    if (i_conBoard.i_conBoardAsserts.failCount != 0) begin
      $display("a bound assertion on the DUT outputs failed");
      $display("TEST RESULT: FAIL");
      $fatal(1, "assertion failure");
    end
  end

  task automatic addRow(input string name, input logic [0:5] c, input logic [0:8] m,
      input bit ctl, input bit rd, input logic [0:2] ds, input logic [0:6] cono,
      input logic [6:0] lv, input int lat, input int sel, input logic [6:0] expected);
    rowName.push_back(name);
    rowCond.push_back(c);
    rowMagic.push_back(m);
    rowCtl.push_back(ctl);
    rowRead.push_back(rd);
    rowDs.push_back(ds);
    rowCono.push_back(cono);
    rowLevels.push_back(lv);
    rowLat.push_back(lat);
    rowSel.push_back(sel);
    rowExp.push_back(expected);
  endtask

  task automatic buildTable();
    // Level bit order is mtrIntReq piReady intDisable userMode publicMode acRef piCycle
    addRow("reset run", 6'o00, 9'o0, 0, 0, 0, 7'h00, 7'b0000000, 1, SEL_RUNSTART, 0);
    addRow("reset pag", 6'o00, 9'o0, 0, 0, 0, 7'h00, 7'b0000000, 0, SEL_PAG, 0);
    addRow("reset ucode", 6'o00, 9'o0, 0, 0, 0, 7'h00, 7'b0000000, 0, SEL_UCODE, 0);
    addRow("reset sr", 6'o00, 9'o0, 0, 0, 0, 7'h00, 7'b0000000, 0, SEL_SR, 0);
    addRow("reset skip", 6'o00, 9'o0, 0, 0, 0, 7'h00, 7'b0000000, 0, SEL_SKIP, 0);
    addRow("reset drive", 6'o00, 9'o0, 0, 0, 0, 7'h00, 7'b0000000, 0, SEL_DRIVE, 0);
    addRow("reset nicond", 6'o00, 9'o0, 0, 0, 0, 7'h00, 7'b0000000, 0, SEL_NICOND, 7'b0011);
    // Run must still be low one cycle before the stated latency
    addRow("set run early", 6'o00, 9'o0, 1, 0, 1, 7'h00, 7'b0000000, SYNC, SEL_RUN, 0);
    addRow("set run", 6'o00, 9'o0, 0, 0, 0, 7'h00, 7'b0000000, 0, SEL_RUN, 1);
    addRow("continue early", 6'o00, 9'o0, 1, 0, 2, 7'h00, 7'b0000000, SYNC, SEL_START, 0);
    addRow("continue", 6'o00, 9'o0, 0, 0, 0, 7'h00, 7'b0000000, 0, SEL_RUNSTART, 7'b11);
    addRow("clear run", 6'o00, 9'o0, 1, 0, 0, 7'h00, 7'b0000000, SYNC + 1, SEL_RUNSTART, 0);
    addRow("set run again", 6'o00, 9'o0, 1, 0, 1, 7'h00, 7'b0000000, SYNC + 1, SEL_RUN, 1);
    addRow("cono pag", 6'o20, 9'o016, 0, 0, 0, 7'b1011010, 7'b0000000, 2, SEL_PAG, 7'b1011);
    addRow("cono other", 6'o20, 9'o017, 0, 0, 0, 7'b0100101, 7'b0000000, 2, SEL_PAG, 7'b1011);
    addRow("sr load", 6'o26, 9'h00d, 0, 0, 0, 7'h00, 7'b0000000, 2, SEL_SR, 7'b1101);
    addRow("ucode set", 6'o21, 9'b010001000, 0, 0, 0, 7'h00, 7'b0000000, 2, SEL_UCODE, 7'b1010);
    addRow("ucode hold", 6'o21, 9'b001100001, 0, 0, 0, 7'h00, 7'b0000000, 2, SEL_UCODE, 7'b1100);
    addRow("skip60 kernel", 6'o60, 9'o0, 0, 0, 0, 7'h00, 7'b0000000, 2, SEL_SKIP, 1);
    addRow("skip60 user", 6'o61, 9'o0, 0, 0, 0, 7'h00, 7'b0001000, 2, SEL_SKIP, 1);
    addRow("skip60 public", 6'o62, 9'o0, 0, 0, 0, 7'h00, 7'b0001000, 2, SEL_SKIP, 0);
    addRow("skip60 acRef", 6'o63, 9'o0, 0, 0, 0, 7'h00, 7'b0000000, 2, SEL_SKIP, 0);
    addRow("skip60 piCycle", 6'o64, 9'o0, 0, 0, 0, 7'h00, 7'b0000001, 2, SEL_SKIP, 1);
    addRow("skip60 paging", 6'o65, 9'o0, 0, 0, 0, 7'h00, 7'b0000000, 2, SEL_SKIP, 1);
    addRow("skip60 not start", 6'o66, 9'o0, 0, 0, 0, 7'h00, 7'b0000000, 2, SEL_SKIP, 1);
    addRow("skip60 trap", 6'o67, 9'o0, 0, 0, 0, 7'h00, 7'b0000000, 2, SEL_SKIP, 1);
    addRow("skip70 intReq", 6'o70, 9'o0, 0, 0, 0, 7'h00, 7'b0100000, 2, SEL_SKIP, 1);
    addRow("skip70 masked", 6'o70, 9'o0, 0, 0, 0, 7'h00, 7'b0110000, 2, SEL_SKIP, 0);
    addRow("skip70 not start", 6'o71, 9'o0, 0, 0, 0, 7'h00, 7'b0000000, 2, SEL_SKIP, 1);
    addRow("skip70 run", 6'o72, 9'o0, 0, 0, 0, 7'h00, 7'b0000000, 2, SEL_SKIP, 1);
    addRow("skip70 kernel", 6'o73, 9'o0, 0, 0, 0, 7'h00, 7'b0001000, 2, SEL_SKIP, 0);
    addRow("skip70 acRef", 6'o74, 9'o0, 0, 0, 0, 7'h00, 7'b0000010, 2, SEL_SKIP, 1);
    addRow("skip70 mtrIntReq", 6'o75, 9'o0, 0, 0, 0, 7'h00, 7'b1000000, 2, SEL_SKIP, 1);
    addRow("skip70 ucode0", 6'o76, 9'o0, 0, 0, 0, 7'h00, 7'b0000000, 2, SEL_SKIP, 1);
    addRow("skip70 not mtr", 6'o77, 9'o0, 0, 0, 0, 7'h00, 7'b1000000, 2, SEL_SKIP, 0);
    addRow("no skip group", 6'o10, 9'o0, 0, 0, 0, 7'h00, 7'b0000010, 2, SEL_SKIP, 0);
    // NICOND result packed as code then trap enable
    addRow("nicond piCycle", 6'o00, 9'o0, 0, 0, 0, 7'h00, 7'b0000001, 2, SEL_NICOND, 7'b0001);
    addRow("nicond mtr", 6'o00, 9'o0, 0, 0, 0, 7'h00, 7'b1000010, 2, SEL_NICOND, 7'b0101);
    addRow("nicond intReq", 6'o00, 9'o0, 0, 0, 0, 7'h00, 7'b0100010, 2, SEL_NICOND, 7'b0111);
    addRow("nicond masked", 6'o00, 9'o0, 0, 0, 0, 7'h00, 7'b0110010, 2, SEL_NICOND, 7'b1110);
    addRow("nicond no acRef", 6'o00, 9'o0, 0, 0, 0, 7'h00, 7'b0000000, 2, SEL_NICOND, 7'b1010);
    addRow("ucode flag2", 6'o21, 9'b001001000, 0, 0, 0, 7'h00, 7'b0000010, 2, SEL_UCODE, 7'b1010);
    addRow("nicond flag2", 6'o00, 9'o0, 0, 0, 0, 7'h00, 7'b0000010, 2, SEL_NICOND, 7'b1000);
    addRow("read group 0", 6'o00, 9'o0, 0, 1, 0, 7'h00, 7'b0000010, 1, SEL_EBUS, 7'b1001011);
    addRow("read drive", 6'o00, 9'o0, 0, 1, 0, 7'h00, 7'b0000010, 0, SEL_DRIVE, 1);
    addRow("read group 1", 6'o00, 9'o0, 0, 1, 1, 7'h00, 7'b0000010, 1, SEL_EBUS, 7'b1010110);
    addRow("read group 2", 6'o00, 9'o0, 0, 1, 2, 7'h00, 7'b0000010, 1, SEL_EBUS, 7'b1000000);
    addRow("read group 5", 6'o00, 9'o0, 0, 1, 5, 7'h00, 7'b0000010, 1, SEL_EBUS, 0);
    addRow("read end", 6'o00, 9'o0, 0, 0, 0, 7'h00, 7'b0000010, 1, SEL_EBUS, 0);
    addRow("read end drive", 6'o00, 9'o0, 0, 0, 0, 7'h00, 7'b0000010, 0, SEL_DRIVE, 0);
    addRow("clear run final", 6'o00, 9'o0, 1, 0, 0, 7'h00, 7'b0000010, SYNC + 1, SEL_RUN, 0);
    addRow("nicond not run", 6'o00, 9'o0, 0, 0, 0, 7'h00, 7'b0000000, 1, SEL_NICOND, 7'b0011);
  endtask

  function automatic logic [6:0] observed(input int sel);
    case (sel)
      SEL_RUN: observed = {6'b0, run};
      SEL_START: observed = {6'b0, start};
      SEL_RUNSTART: observed = {5'b0, run, start};
      SEL_PAG: observed = {3'b0, pag};
      SEL_UCODE: observed = {3'b0, ucodeState};
      SEL_SR: observed = {3'b0, sr};
      SEL_SKIP: observed = {6'b0, skip};
      SEL_NICOND: observed = {3'b0, nicond, nicondTrapEn};
      SEL_EBUS: observed = ebusOut;
      default: observed = {6'b0, ebusDrive};
    endcase
  endfunction

  task automatic checkValue(input string name, input logic [6:0] expected,
      input logic [6:0] actual);
    if (actual !== expected) begin
      $display("error %s: expected %b, actual %b", name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic waitEdges(input int n);
    if (n > WAIT_LIMIT) begin
      $display("a wait of %0d cycles is longer than the %0d cycle timeout", n, WAIT_LIMIT);
      $display("TEST RESULT: FAIL");
      $fatal(1, "wait timeout");
    end else begin
      for (int k = 0; k < n; k++) begin
        @(posedge clk);
      end
    end
  endtask

  // Microword goes back to a no-op group once its strobe cycle is over
  task automatic driveIdleWord();
    cond <= '0;
    magic <= conPkg::magicField'($urandom);
    diagCtlFunc <= 1'b0;
  endtask

  initial begin
    int seedDummy;
    seedDummy = $urandom(32'hcf7b);
    rst = 1'b1;
    cond = '0;
    magic = '0;
    diagCtlFunc = 1'b0;
    diagReadFunc = 1'b0;
    diagDs = '0;
    conoData = '0;
    {mtrIntReq, piReady, intDisable, userMode, publicMode, acRef, piCycle} = '0;
    buildTable();
    waitEdges(16);
    rst <= 1'b0;
    for (int i = 0; i < rowName.size(); i++) begin
      waitEdges(1);
      cond <= rowCond[i];
      magic <= rowMagic[i];
      diagCtlFunc <= rowCtl[i];
      diagReadFunc <= rowRead[i];
      diagDs <= rowDs[i];
      conoData <= rowCono[i];
      {mtrIntReq, piReady, intDisable, userMode, publicMode, acRef, piCycle} <= rowLevels[i];
      if (rowLat[i] > 0) begin
        waitEdges(1);
        driveIdleWord();
        waitEdges(rowLat[i] - 1);
      end
      @(negedge clk);
      checkValue(rowName[i], rowExp[i], observed(rowSel[i]));
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
verilog/conPkg.sv
verilog/condDecoder.sv
verilog/runControl.sv
verilog/skipNicond.sv
verilog/conBoard.sv
dv/conBoard_asserts.sv
dv/conBoardTb.sv
